// File: design/axi_rd_demux_pkg.sv
package axi_rd_demux_pkg;

  // ------------------------------
  // axi field widths
  // ------------------------------

  // transaction id, shared by ar and r
  localparam int unsigned ID_W   = 4;
  // byte address
  localparam int unsigned ADDR_W = 32;
  // one r data beat
  localparam int unsigned DATA_W = 32;
  // burst length, beats minus one
  localparam int unsigned LEN_W  = 8;

  // ------------------------------
  // default sizes
  // ------------------------------

  // master ports behind the demux
  localparam int unsigned NUM_PORTS_DEF = 3;
  // reads in flight per tracked id
  localparam int unsigned MAX_TRANS_DEF = 8;
  // low id bits that get their own counter
  localparam int unsigned LOOK_BITS_DEF = 2;

endpackage

// File: design/rd_id_counters.sv
module rd_id_counters #(
  parameter int unsigned SEL_W     = 2,
  parameter int unsigned MAX_TRANS = axi_rd_demux_pkg::MAX_TRANS_DEF,
  parameter int unsigned LOOK_BITS = axi_rd_demux_pkg::LOOK_BITS_DEF
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // lookup of the id that waits on the slave ar
  input  logic [LOOK_BITS-1:0] lookup_id_i,
  output logic [SEL_W-1:0]     lookup_sel_o,
  output logic                 lookup_occupied_o,
  // any counter at its limit
  output logic                 full_o,
  // push on ar handshake
  input  logic                 push_i,
  input  logic [LOOK_BITS-1:0] push_id_i,
  input  logic [SEL_W-1:0]     push_sel_i,
  // pop on last r beat
  input  logic                 pop_i,
  input  logic [LOOK_BITS-1:0] pop_id_i
);

  // one counter per value of the tracked id bits
  localparam int unsigned NUM_CNT = 2 ** LOOK_BITS;
  // full means all ones, so MAX_TRANS 4 stops at three in flight
  localparam int unsigned CNT_W   = (MAX_TRANS > 1) ? $clog2(MAX_TRANS) : 1;

  logic [NUM_CNT-1:0][CNT_W-1:0] cnt_q;
  logic [NUM_CNT-1:0][SEL_W-1:0] sel_q;
  logic [NUM_CNT-1:0]            push_en;
  logic [NUM_CNT-1:0]            pop_en;
  logic [NUM_CNT-1:0]            occupied;
  logic [NUM_CNT-1:0]            cnt_full;

  // ------------------------------
  // decode of push and pop ids
  // ------------------------------
  always_comb begin
    for (int i = 0; i < NUM_CNT; i++) begin
      push_en[i] = push_i && (push_id_i == LOOK_BITS'(i));
      pop_en[i]  = pop_i && (pop_id_i == LOOK_BITS'(i));
    end
  end

  // ------------------------------
  // in-flight counters
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      sel_q <= '0;
    end else begin
      for (int i = 0; i < NUM_CNT; i++) begin
        // push and pop together cancel out
        if (push_en[i] && !pop_en[i]) begin
          cnt_q[i] <= cnt_q[i] + CNT_W'(1);
        end else if (pop_en[i] && !push_en[i]) begin
          cnt_q[i] <= cnt_q[i] - CNT_W'(1);
        end
        // remember where this id went
        if (push_en[i]) begin
          sel_q[i] <= push_sel_i;
        end
      end
    end
  end

  // status per counter
  for (genvar i = 0; i < NUM_CNT; i++) begin : gen_status
    assign occupied[i] = |cnt_q[i];
    assign cnt_full[i] = &cnt_q[i];
  end

  // lookup is purely combinational
  assign lookup_sel_o      = sel_q[lookup_id_i];
  assign lookup_occupied_o = occupied[lookup_id_i];
  assign full_o            = |cnt_full;

endmodule

// File: design/ar_router.sv
module ar_router #(
  parameter int unsigned NUM_PORTS = axi_rd_demux_pkg::NUM_PORTS_DEF,
  parameter int unsigned SEL_W     = 2,
  parameter int unsigned MAX_TRANS = axi_rd_demux_pkg::MAX_TRANS_DEF,
  parameter int unsigned LOOK_BITS = axi_rd_demux_pkg::LOOK_BITS_DEF
) (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // slave ar
  input  logic                                          ar_valid_i,
  output logic                                          ar_ready_o,
  input  logic [axi_rd_demux_pkg::ID_W-1:0]             ar_id_i,
  input  logic [axi_rd_demux_pkg::ADDR_W-1:0]           ar_addr_i,
  input  logic [axi_rd_demux_pkg::LEN_W-1:0]            ar_len_i,
  input  logic [SEL_W-1:0]                              ar_sel_i,
  // master ar, flattened over the ports
  output logic [NUM_PORTS-1:0]                          m_ar_valid_o,
  input  logic [NUM_PORTS-1:0]                          m_ar_ready_i,
  output logic [NUM_PORTS*axi_rd_demux_pkg::ID_W-1:0]   m_ar_id_o,
  output logic [NUM_PORTS*axi_rd_demux_pkg::ADDR_W-1:0] m_ar_addr_o,
  output logic [NUM_PORTS*axi_rd_demux_pkg::LEN_W-1:0]  m_ar_len_o,
  // slave r as seen at the port, for the pop
  input  logic                                          r_valid_i,
  input  logic                                          r_ready_i,
  input  logic [axi_rd_demux_pkg::ID_W-1:0]             r_id_i,
  input  logic                                          r_last_i
);

  logic [SEL_W-1:0] lookup_sel;
  logic             lookup_occupied;
  logic             cnt_full;
  logic             sel_ready;
  logic             ar_valid;
  logic             ar_push;
  logic             pop;
  logic             lock_d;
  logic             lock_q;

  // ------------------------------
  // ready of the selected port
  // ------------------------------
  always_comb begin
    sel_ready = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (ar_sel_i == SEL_W'(i)) begin
        sel_ready = m_ar_ready_i[i];
      end
    end
  end

  // ------------------------------
  // ar acceptance
  // ------------------------------
  always_comb begin
    ar_valid = 1'b0;
    ar_push  = 1'b0;
    lock_d   = lock_q;
    if (lock_q) begin
      // valid already shown, counter flags no longer matter
      ar_valid = 1'b1;
      if (sel_ready) begin
        ar_push = 1'b1;
        lock_d  = 1'b0;
      end
    end else if (ar_valid_i && !cnt_full &&
                 (!lookup_occupied || (lookup_sel == ar_sel_i))) begin
      // id free or bound to the same port
      ar_valid = 1'b1;
      if (sel_ready) begin
        ar_push = 1'b1;
      end else begin
        lock_d = 1'b1;
      end
    end
  end

  // keeps a presented valid up until ready
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  assign ar_ready_o = ar_valid & sel_ready;

  // only the selected port sees valid
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      m_ar_valid_o[i] = ar_valid && (ar_sel_i == SEL_W'(i));
    end
  end

  // payload copied to every port
  assign m_ar_id_o   = {NUM_PORTS{ar_id_i}};
  assign m_ar_addr_o = {NUM_PORTS{ar_addr_i}};
  assign m_ar_len_o  = {NUM_PORTS{ar_len_i}};

  // read done once its last beat leaves the slave port
  assign pop = r_valid_i & r_ready_i & r_last_i;

  rd_id_counters #(
    .SEL_W     (SEL_W),
    .MAX_TRANS (MAX_TRANS),
    .LOOK_BITS (LOOK_BITS)
  ) rd_id_counters_i (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .lookup_id_i       (ar_id_i[LOOK_BITS-1:0]),
    .lookup_sel_o      (lookup_sel),
    .lookup_occupied_o (lookup_occupied),
    .full_o            (cnt_full),
    .push_i            (ar_push),
    .push_id_i         (ar_id_i[LOOK_BITS-1:0]),
    .push_sel_i        (ar_sel_i),
    .pop_i             (pop),
    .pop_id_i          (r_id_i[LOOK_BITS-1:0])
  );

endmodule

// File: design/r_rr_arbiter.sv
module r_rr_arbiter #(
  parameter int unsigned NUM_PORTS = axi_rd_demux_pkg::NUM_PORTS_DEF,
  parameter int unsigned SEL_W     = 2
) (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // master r, flattened over the ports
  input  logic [NUM_PORTS-1:0]                          m_r_valid_i,
  output logic [NUM_PORTS-1:0]                          m_r_ready_o,
  input  logic [NUM_PORTS*axi_rd_demux_pkg::ID_W-1:0]   m_r_id_i,
  input  logic [NUM_PORTS*axi_rd_demux_pkg::DATA_W-1:0] m_r_data_i,
  input  logic [NUM_PORTS-1:0]                          m_r_last_i,
  // slave r
  output logic                                          r_valid_o,
  input  logic                                          r_ready_i,
  output logic [axi_rd_demux_pkg::ID_W-1:0]             r_id_o,
  output logic [axi_rd_demux_pkg::DATA_W-1:0]           r_data_o,
  output logic                                          r_last_o
);

  logic [SEL_W-1:0] ptr_q;
  logic [SEL_W-1:0] lock_idx_q;
  logic             lock_q;
  logic [SEL_W-1:0] rr_idx;
  logic             rr_found;
  logic [SEL_W-1:0] gnt_idx;
  logic             handshake;

  // ------------------------------
  // round-robin search
  // ------------------------------
  // first valid port at or after the pointer
  always_comb begin : rr_search
    int unsigned cand;
    rr_idx   = ptr_q;
    rr_found = 1'b0;
    for (int unsigned k = 0; k < NUM_PORTS; k++) begin
      cand = ptr_q + k;
      // wrap around the port count
      if (cand >= NUM_PORTS) begin
        cand = cand - NUM_PORTS;
      end
      if (!rr_found && m_r_valid_i[cand]) begin
        rr_found = 1'b1;
        rr_idx   = SEL_W'(cand);
      end
    end
  end

  // a locked grant wins over the search
  assign gnt_idx   = lock_q ? lock_idx_q : rr_idx;
  assign r_valid_o = lock_q ? m_r_valid_i[lock_idx_q] : rr_found;
  assign handshake = r_valid_o & r_ready_i;

  // beat of the granted port
  assign r_id_o   = m_r_id_i[gnt_idx*axi_rd_demux_pkg::ID_W +: axi_rd_demux_pkg::ID_W];
  assign r_data_o = m_r_data_i[gnt_idx*axi_rd_demux_pkg::DATA_W +: axi_rd_demux_pkg::DATA_W];
  assign r_last_o = m_r_last_i[gnt_idx];

  // ready goes back to the granted port only
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      m_r_ready_o[i] = handshake && (gnt_idx == SEL_W'(i));
    end
  end

  // ------------------------------
  // pointer and lock-in
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (handshake) begin
      // move past the port just served
      lock_q <= 1'b0;
      ptr_q  <= (gnt_idx == SEL_W'(NUM_PORTS - 1)) ? '0 : gnt_idx + SEL_W'(1);
    end else if (r_valid_o && !lock_q) begin
      // back-pressure, hold this grant
      lock_q     <= 1'b1;
      lock_idx_q <= rr_idx;
    end
  end

endmodule

// File: design/axi_rd_demux.sv
module axi_rd_demux #(
  parameter int unsigned NUM_PORTS = axi_rd_demux_pkg::NUM_PORTS_DEF,
  parameter int unsigned MAX_TRANS = axi_rd_demux_pkg::MAX_TRANS_DEF,
  parameter int unsigned LOOK_BITS = axi_rd_demux_pkg::LOOK_BITS_DEF,
  // port select width, shared by router and arbiter
  localparam int unsigned SEL_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // ------------------------------
  // slave port
  // ------------------------------
  input  logic                                          ar_valid_i,
  output logic                                          ar_ready_o,
  input  logic [axi_rd_demux_pkg::ID_W-1:0]             ar_id_i,
  input  logic [axi_rd_demux_pkg::ADDR_W-1:0]           ar_addr_i,
  input  logic [axi_rd_demux_pkg::LEN_W-1:0]            ar_len_i,
  // target port, stable while ar_valid_i is high
  input  logic [SEL_W-1:0]                              ar_sel_i,
  output logic                                          r_valid_o,
  input  logic                                          r_ready_i,
  output logic [axi_rd_demux_pkg::ID_W-1:0]             r_id_o,
  output logic [axi_rd_demux_pkg::DATA_W-1:0]           r_data_o,
  output logic                                          r_last_o,
  // ------------------------------
  // master ports
  // ------------------------------
  output logic [NUM_PORTS-1:0]                          m_ar_valid_o,
  input  logic [NUM_PORTS-1:0]                          m_ar_ready_i,
  output logic [NUM_PORTS*axi_rd_demux_pkg::ID_W-1:0]   m_ar_id_o,
  output logic [NUM_PORTS*axi_rd_demux_pkg::ADDR_W-1:0] m_ar_addr_o,
  output logic [NUM_PORTS*axi_rd_demux_pkg::LEN_W-1:0]  m_ar_len_o,
  input  logic [NUM_PORTS-1:0]                          m_r_valid_i,
  output logic [NUM_PORTS-1:0]                          m_r_ready_o,
  input  logic [NUM_PORTS*axi_rd_demux_pkg::ID_W-1:0]   m_r_id_i,
  input  logic [NUM_PORTS*axi_rd_demux_pkg::DATA_W-1:0] m_r_data_i,
  input  logic [NUM_PORTS-1:0]                          m_r_last_i
);

  // ar side with the id counters
  // pops from the slave r handshake below
  ar_router #(
    .NUM_PORTS (NUM_PORTS),
    .SEL_W     (SEL_W),
    .MAX_TRANS (MAX_TRANS),
    .LOOK_BITS (LOOK_BITS)
  ) ar_router_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ar_valid_i   (ar_valid_i),
    .ar_ready_o   (ar_ready_o),
    .ar_id_i      (ar_id_i),
    .ar_addr_i    (ar_addr_i),
    .ar_len_i     (ar_len_i),
    .ar_sel_i     (ar_sel_i),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .m_ar_id_o    (m_ar_id_o),
    .m_ar_addr_o  (m_ar_addr_o),
    .m_ar_len_o   (m_ar_len_o),
    .r_valid_i    (r_valid_o),
    .r_ready_i    (r_ready_i),
    .r_id_i       (r_id_o),
    .r_last_i     (r_last_o)
  );

  // r merge back onto the slave port
  r_rr_arbiter #(
    .NUM_PORTS (NUM_PORTS),
    .SEL_W     (SEL_W)
  ) r_rr_arbiter_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .m_r_valid_i (m_r_valid_i),
    .m_r_ready_o (m_r_ready_o),
    .m_r_id_i    (m_r_id_i),
    .m_r_data_i  (m_r_data_i),
    .m_r_last_i  (m_r_last_i),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .r_id_o      (r_id_o),
    .r_data_o    (r_data_o),
    .r_last_o    (r_last_o)
  );

endmodule

// File: tb/axi_rd_demux_checker.sv
module axi_rd_demux_checker #(
  parameter int unsigned NUM_PORTS = axi_rd_demux_pkg::NUM_PORTS_DEF
) (
  input logic                                        clk_i,
  input logic                                        rst_n_i,
  input logic [NUM_PORTS-1:0]                        m_ar_valid_o,
  input logic [NUM_PORTS-1:0]                        m_ar_ready_i,
  input logic [NUM_PORTS*axi_rd_demux_pkg::ID_W-1:0] m_ar_id_o,
  input logic                                        r_valid_o,
  input logic                                        r_ready_i,
  input logic [axi_rd_demux_pkg::DATA_W-1:0]         r_data_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // ------------------------------
  // master ar handshakes
  // ------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_ar_hold
    // valid held with a stable id until ready
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_ar_valid_o[i] && !m_ar_ready_i[i] |=> m_ar_valid_o[i] &&
      $stable(m_ar_id_o[i*axi_rd_demux_pkg::ID_W +: axi_rd_demux_pkg::ID_W]))
      else $error("master ar valid dropped or id changed before ready");
  end

  // never more than one port addressed
  assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(m_ar_valid_o))
    else $error("more than one master ar valid high");

  // slave r beat held under back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o))
    else $error("slave r beat changed under back-pressure");

endmodule

bind axi_rd_demux axi_rd_demux_checker #(
  .NUM_PORTS (NUM_PORTS)
) checker_i (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .m_ar_valid_o (m_ar_valid_o),
  .m_ar_ready_i (m_ar_ready_i),
  .m_ar_id_o    (m_ar_id_o),
  .r_valid_o    (r_valid_o),
  .r_ready_i    (r_ready_i),
  .r_data_o     (r_data_o)
);

// File: tb/tb_axi_rd_demux.sv
module tb_axi_rd_demux;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NP      = 3;
  localparam int unsigned SEL_W   = 2;
  localparam int unsigned ID_W    = axi_rd_demux_pkg::ID_W;
  localparam int unsigned ADDR_W  = axi_rd_demux_pkg::ADDR_W;
  localparam int unsigned DATA_W  = axi_rd_demux_pkg::DATA_W;
  localparam int unsigned LEN_W   = axi_rd_demux_pkg::LEN_W;
  // rows in the data file, five words each
  localparam int unsigned NUM_REQ = 14;

  logic                 clk_i = 1'b0;
  logic                 rst_n_i;
  logic                 ar_valid_i;
  logic                 ar_ready_o;
  logic [ID_W-1:0]      ar_id_i;
  logic [ADDR_W-1:0]    ar_addr_i;
  logic [LEN_W-1:0]     ar_len_i;
  logic [SEL_W-1:0]     ar_sel_i;
  logic                 r_valid_o;
  logic                 r_ready_i;
  logic [ID_W-1:0]      r_id_o;
  logic [DATA_W-1:0]    r_data_o;
  logic                 r_last_o;
  logic [NP-1:0]        m_ar_valid_o;
  logic [NP-1:0]        m_ar_ready_i;
  logic [NP*ID_W-1:0]   m_ar_id_o;
  logic [NP*ADDR_W-1:0] m_ar_addr_o;
  logic [NP*LEN_W-1:0]  m_ar_len_o;
  logic [NP-1:0]        m_r_valid_i;
  logic [NP-1:0]        m_r_ready_o;
  logic [NP*ID_W-1:0]   m_r_id_i;
  logic [NP*DATA_W-1:0] m_r_data_i;
  logic [NP-1:0]        m_r_last_i;

  // sel, id, addr, len, expected first word per row
  logic [31:0] td [0:NUM_REQ*5-1];
  int unsigned row_idx;
  int unsigned total_beats;
  int unsigned rx_beats;
  int unsigned cycles;
  int unsigned cycle_limit;
  logic [31:0] lfsr_q;

  // responder state per master port
  logic [ADDR_W-1:0] rsp_addr [NP][0:31];
  logic [LEN_W-1:0]  rsp_len  [NP][0:31];
  logic [ID_W-1:0]   rsp_id   [NP][0:31];
  int unsigned       rsp_wr   [NP];
  int unsigned       rsp_rd   [NP];
  int unsigned       rsp_beat [NP];

  // scoreboard, expected beats per full id
  logic [DATA_W-1:0] exp_data [16][0:63];
  logic              exp_last [16][0:63];
  int unsigned       exp_head [16];
  int unsigned       exp_tail [16];
  // reads in flight per tracked id and the port they went to
  int unsigned       inflight [4];
  logic [SEL_W-1:0]  bound    [4];
  logic              saw_full;
  logic              saw_hold;
  logic              saw_parallel;

  axi_rd_demux #(
    .NUM_PORTS (NP),
    .MAX_TRANS (4),
    .LOOK_BITS (2)
  ) axi_rd_demux_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ar_valid_i   (ar_valid_i),
    .ar_ready_o   (ar_ready_o),
    .ar_id_i      (ar_id_i),
    .ar_addr_i    (ar_addr_i),
    .ar_len_i     (ar_len_i),
    .ar_sel_i     (ar_sel_i),
    .r_valid_o    (r_valid_o),
    .r_ready_i    (r_ready_i),
    .r_id_o       (r_id_o),
    .r_data_o     (r_data_o),
    .r_last_o     (r_last_o),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .m_ar_id_o    (m_ar_id_o),
    .m_ar_addr_o  (m_ar_addr_o),
    .m_ar_len_o   (m_ar_len_o),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_ready_o  (m_r_ready_o),
    .m_r_id_i     (m_r_id_i),
    .m_r_data_i   (m_r_data_i),
    .m_r_last_i   (m_r_last_i)
  );

  always #50 clk_i = ~clk_i;

  // ------------------------------
  // helpers
  // ------------------------------
  // galois lfsr, one step per bit
  function automatic logic next_random_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return b;
  endfunction

  // responder data rule, port number in the top byte
  function automatic logic [DATA_W-1:0] beat_word(input int unsigned port,
                                                  input logic [ADDR_W-1:0] addr,
                                                  input int unsigned k);
    logic [ADDR_W-1:0] a;
    a = addr + ADDR_W'(k);
    return {8'(port), a[23:0]};
  endfunction

  task automatic report_failure(input string what);
    $display("%s at %0t", what, $time);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped");
    end
  endtask

  // ------------------------------
  // master responders and r_ready
  // ------------------------------
  always @(negedge clk_i) begin : drive_masters
    int unsigned e;
    for (int p = 0; p < NP; p++) begin
      m_ar_ready_i[p] = next_random_bit();
      e = rsp_rd[p];
      if (rsp_rd[p] != rsp_wr[p]) begin
        // beat stays put until its handshake moves rsp_beat
        m_r_valid_i[p]                 = 1'b1;
        m_r_id_i[p*ID_W +: ID_W]       = rsp_id[p][e];
        m_r_data_i[p*DATA_W +: DATA_W] = beat_word(p, rsp_addr[p][e], rsp_beat[p]);
        m_r_last_i[p]                  = (rsp_beat[p] == int'(rsp_len[p][e]));
      end else begin
        m_r_valid_i[p] = 1'b0;
        m_r_last_i[p]  = 1'b0;
      end
    end
    r_ready_i = next_random_bit();
  end

  // ------------------------------
  // monitor and scoreboard
  // ------------------------------
  always @(posedge clk_i) begin : monitor
    logic [1:0]  low;
    logic [3:0]  rid;
    int unsigned len;
    low = ar_id_i[1:0];
    rid = r_id_o;
    len = ar_len_i;
    if (rst_n_i) begin
      // master ar routing and ordering hold
      for (int p = 0; p < NP; p++) begin
        if (m_ar_valid_o[p]) begin
          check_value("ar_valid_i behind m_ar_valid_o", ar_valid_i, 1'b1);
          check_value("m_ar_valid_o port", p, ar_sel_i);
          check_value("m_ar_id_o", m_ar_id_o[p*ID_W +: ID_W], ar_id_i);
          check_value("m_ar_addr_o", m_ar_addr_o[p*ADDR_W +: ADDR_W], ar_addr_i);
          check_value("m_ar_len_o", m_ar_len_o[p*LEN_W +: LEN_W], ar_len_i);
          if (inflight[low] != 0) begin
            check_value("m_ar_valid_o port of busy id", p, bound[low]);
          end
          if (m_ar_ready_i[p]) begin
            rsp_addr[p][rsp_wr[p]] = ar_addr_i;
            rsp_len[p][rsp_wr[p]]  = ar_len_i;
            rsp_id[p][rsp_wr[p]]   = ar_id_i;
            rsp_wr[p]++;
          end
        end
        // responder moves on after its beat is taken
        if (m_r_valid_i[p] && m_r_ready_o[p]) begin
          if (m_r_last_i[p]) begin
            rsp_rd[p]++;
            rsp_beat[p] = 0;
          end else begin
            rsp_beat[p]++;
          end
        end
      end
      // slave r beat against the expected queue
      if (r_valid_o && r_ready_i) begin
        if (exp_head[rid] == exp_tail[rid]) begin
          report_failure("r beat arrived with no read outstanding for its id");
        end
        check_value("r_data_o", r_data_o, exp_data[rid][exp_head[rid]]);
        check_value("r_last_o", r_last_o, exp_last[rid][exp_head[rid]]);
        exp_head[rid]++;
        rx_beats++;
        if (r_last_o) begin
          inflight[rid[1:0]]--;
        end
      end
      // coverage of the stall cases
      if (ar_valid_i && !ar_ready_o && inflight[low] == 3) begin
        saw_full = 1'b1;
      end
      if (ar_valid_i && !ar_ready_o && inflight[low] != 0 && bound[low] != ar_sel_i) begin
        saw_hold = 1'b1;
      end
      // slave ar handshake
      if (ar_valid_i && ar_ready_o) begin
        if (inflight[low] >= 3) begin
          report_failure("read accepted while its id counter was full");
        end
        for (int unsigned k = 0; k <= len; k++) begin
          exp_data[ar_id_i][exp_tail[ar_id_i]] = (k == 0) ? td[row_idx*5+4] :
                                                 beat_word(ar_sel_i, ar_addr_i, k);
          exp_last[ar_id_i][exp_tail[ar_id_i]] = (k == len);
          exp_tail[ar_id_i]++;
        end
        inflight[low]++;
        bound[low] = ar_sel_i;
      end
      for (int i = 0; i < 4; i++) begin
        for (int j = i + 1; j < 4; j++) begin
          if (inflight[i] != 0 && inflight[j] != 0 && bound[i] != bound[j]) begin
            saw_parallel = 1'b1;
          end
        end
      end
    end
  end

  // run limit from the beat count
  always @(posedge clk_i) begin : watchdog
    if (rst_n_i) begin
      cycles++;
      if (cycles > cycle_limit) begin
        report_failure("timeout, not all read beats arrived in time");
      end
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin : stimulus
    rst_n_i      = 1'b0;
    ar_valid_i   = 1'b0;
    ar_id_i      = '0;
    ar_addr_i    = '0;
    ar_len_i     = '0;
    ar_sel_i     = '0;
    r_ready_i    = 1'b0;
    m_ar_ready_i = '0;
    m_r_valid_i  = '0;
    m_r_id_i     = '0;
    m_r_data_i   = '0;
    m_r_last_i   = '0;
    lfsr_q       = 32'h2346_9a5f;
    row_idx      = 0;
    rx_beats     = 0;
    cycles       = 0;
    saw_full     = 1'b0;
    saw_hold     = 1'b0;
    saw_parallel = 1'b0;
    for (int p = 0; p < NP; p++) begin
      rsp_wr[p]   = 0;
      rsp_rd[p]   = 0;
      rsp_beat[p] = 0;
    end
    for (int i = 0; i < 16; i++) begin
      exp_head[i] = 0;
      exp_tail[i] = 0;
    end
    for (int i = 0; i < 4; i++) begin
      inflight[i] = 0;
      bound[i]    = '0;
    end
    $readmemh("tb/axi_rd_demux_testdata.txt", td);
    total_beats = 0;
    for (int r = 0; r < NUM_REQ; r++) begin
      total_beats += td[r*5+3] + 1;
    end
    cycle_limit = 40 * total_beats;

    // outputs quiet in reset and just after it
    repeat (5) begin
      @(posedge clk_i);
      check_value("ar_ready_o", ar_ready_o, 1'b0);
      check_value("r_valid_o", r_valid_o, 1'b0);
      check_value("m_ar_valid_o", m_ar_valid_o, '0);
    end
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(posedge clk_i);
    check_value("ar_ready_o", ar_ready_o, 1'b0);
    check_value("r_valid_o", r_valid_o, 1'b0);
    check_value("m_ar_valid_o", m_ar_valid_o, '0);

    // one request per row, held until accepted
    for (int r = 0; r < NUM_REQ; r++) begin
      @(negedge clk_i);
      row_idx    = r;
      ar_sel_i   = td[r*5][SEL_W-1:0];
      ar_id_i    = td[r*5+1][ID_W-1:0];
      ar_addr_i  = td[r*5+2];
      ar_len_i   = td[r*5+3][LEN_W-1:0];
      ar_valid_i = 1'b1;
      do begin
        @(posedge clk_i);
      end while (!ar_ready_o);
    end
    @(negedge clk_i);
    ar_valid_i = 1'b0;

    while (rx_beats != total_beats) begin
      @(negedge clk_i);
    end
    // no beat may follow the last expected one
    repeat (8) begin
      @(posedge clk_i);
      check_value("r_valid_o", r_valid_o, 1'b0);
    end
    check_value("full stall seen", saw_full, 1'b1);
    check_value("ordering hold seen", saw_hold, 1'b1);
    check_value("parallel reads seen", saw_parallel, 1'b1);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: tb/axi_rd_demux_testdata.txt
// columns: sel id addr len first_word
// first_word is the address with the port number in the top byte
00000000 00000001 00001000 00000003 00001000
00000001 00000002 00002000 00000001 01002000
00000002 00000003 00003000 00000000 02003000
// two long reads to different ports, in flight together
00000000 00000006 00010000 0000000f 00010000
00000001 00000007 00020000 0000000f 01020000
// same low id bits, different port, second must wait
00000001 00000005 00030000 00000007 01030000
00000002 00000009 00040000 00000000 02040000
// four reads of one id, the fourth stalls on full
00000002 00000004 00050000 00000007 02050000
00000002 00000004 00060000 00000007 02060000
00000002 00000004 00070000 00000007 02070000
00000002 00000004 00080000 00000003 02080000
// mixed tail
00000000 00000008 00090000 00000002 00090000
00000001 0000000a 000a0000 00000005 010a0000
00000002 0000000b 000b0000 00000001 020b0000

// File: axi_rd_demux.f
design/axi_rd_demux_pkg.sv
design/rd_id_counters.sv
design/ar_router.sv
design/r_rr_arbiter.sv
design/axi_rd_demux.sv
tb/axi_rd_demux_checker.sv
tb/tb_axi_rd_demux.sv

// File: Makefile
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module tb_axi_rd_demux -f axi_rd_demux.f

run: build
	./obj_dir/Vtb_axi_rd_demux > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "simulation incomplete"; exit 1; fi

lint:
	verilator --lint-only -Wall --top-module axi_rd_demux design/axi_rd_demux_pkg.sv \
		design/rd_id_counters.sv design/ar_router.sv design/r_rr_arbiter.sv \
		design/axi_rd_demux.sv

clean:
	rm -rf obj_dir $(LOG)
